//--- mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data and address width.
`define XLEN 32

// General purpose registers.
`define NUM_REGS 32

// First fetch address.
`define RESET_PC 32'h0000_0000

`endif

//--- mips_pkg.sv
package mips_pkg;

    // ##################################################
    // Instruction word views
    // ##################################################
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] target;
        } j;
    } instr_u;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDIU = 6'h09,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // ##################################################
    // Execute controls carried through ID/EX
    // ##################################################
    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src_imm;  // B operand from immediate.
        logic       ext_signed;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;       // beq.
        logic       jump;
        logic [4:0] wr_reg;
    } ex_ctrl_t;

endpackage

//--- wb_if.sv
`include "mips_settings.svh"

interface wb_if;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [`XLEN-1:0] adr;
    logic [`XLEN-1:0] dat_w;
    logic [`XLEN-1:0] dat_r;
    logic             ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );
endinterface

//--- fetch_unit.sv
`include "mips_settings.svh"

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    wb_if.master             bus,
    input  logic             stall,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    output logic [`XLEN-1:0] if_instr,
    output logic [`XLEN-1:0] if_pc,
    output logic             if_valid
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] adr_q;
    logic             cyc_q;
    logic             kill_q;   // In-flight word is stale.
    logic             take;

    // Word lands in IF/ID only when nothing downstream objects.
    assign take = cyc_q & bus.ack & ~kill_q & ~redirect & ~stall;

    assign bus.cyc   = cyc_q;
    assign bus.stb   = cyc_q;
    assign bus.we    = 1'b0;     // Read only.
    assign bus.adr   = adr_q;
    assign bus.dat_w = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            cyc_q    <= 1'b0;
            kill_q   <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (cyc_q) begin
                if (bus.ack) begin
                    cyc_q  <= 1'b0;  // Drop one cycle after ack.
                    kill_q <= 1'b0;
                end else if (redirect) begin
                    kill_q <= 1'b1;
                end
            end else if (!stall && !redirect) begin
                cyc_q <= 1'b1;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end else if (take) begin
                pc <= adr_q + `XLEN'd4;
            end
            // Refetch of a dropped word keeps pc as is.
            if (redirect) begin
                if_valid <= 1'b0;
            end else if (!stall) begin
                if_valid <= take;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!cyc_q) begin
            adr_q <= pc;     // Stable for the whole cycle.
        end
        if (take) begin
            if_instr <= bus.dat_r;
            if_pc    <= adr_q;
        end
    end

endmodule

//--- decode_stage.sv
`include "mips_settings.svh"

module decode_stage
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] if_instr,
    input  logic [`XLEN-1:0] if_pc,
    input  logic             if_valid,
    input  logic             wb_en,
    input  logic [4:0]       wb_reg,
    input  logic [`XLEN-1:0] wb_data,
    output logic [`XLEN-1:0] op_a,
    output logic [`XLEN-1:0] op_b,
    output logic [`XLEN-1:0] imm_ext,
    output logic [`XLEN-1:0] pc,
    output ex_ctrl_t         ctrl
);

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    instr_u           ins;
    logic [`XLEN-1:0] regs [`NUM_REGS];

    assign ins = if_instr;
    assign pc  = if_pc;

    // ##################################################
    // Control decode
    // ##################################################
    always_comb begin
        ctrl = '0;
        if (if_valid) begin
            case (opcode_e'(ins.i.op))
                OP_RTYPE: begin
                    ctrl.wr_reg    = ins.r.rd;
                    ctrl.reg_write = 1'b1;
                    case (ins.r.funct)
                        FN_ADDU: ctrl.alu_op = ALU_ADD;
                        FN_SUBU: ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_OR:   ctrl.alu_op = ALU_OR;
                        FN_SLT:  ctrl.alu_op = ALU_SLT;
                        default: ctrl.reg_write = 1'b0;  // Unsupported, no-op.
                    endcase
                end
                OP_ADDIU, OP_LW: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.ext_signed  = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.mem_read    = (ins.i.op == OP_LW);
                    ctrl.wr_reg      = ins.i.rt;
                end
                OP_ORI, OP_LUI: begin
                    ctrl.alu_op      = (ins.i.op == OP_ORI) ? ALU_OR : ALU_LUI;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.wr_reg      = ins.i.rt;
                end
                OP_SW: begin
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.ext_signed  = 1'b1;
                    ctrl.mem_write   = 1'b1;
                end
                OP_BEQ: begin
                    ctrl.ext_signed = 1'b1;   // Word offset.
                    ctrl.branch     = 1'b1;
                end
                OP_J:    ctrl.jump = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    always_comb begin
        if (ctrl.jump) begin
            imm_ext = {6'b0, ins.j.target};
        end else if (ctrl.ext_signed) begin
            imm_ext = {{(`XLEN-16){ins.i.imm[15]}}, ins.i.imm};
        end else begin
            imm_ext = {{(`XLEN-16){1'b0}}, ins.i.imm};
        end
    end

    // ##################################################
    // Register file
    // ##################################################
    function automatic logic [`XLEN-1:0] read_reg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end else if (wb_en && wb_reg == idx) begin
            return wb_data;   // Same-cycle write passes through.
        end
        return regs[idx];
    endfunction

    assign op_a = read_reg(ins.r.rs);
    assign op_b = read_reg(ins.r.rt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && wb_reg != 5'd0) begin
            regs[wb_reg] <= wb_data;
        end
    end

endmodule

//--- id_ex.sv
`include "mips_settings.svh"

module id_ex
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             flush,
    input  logic [`XLEN-1:0] op_a,
    input  logic [`XLEN-1:0] op_b,
    input  logic [`XLEN-1:0] imm_ext,
    input  logic [`XLEN-1:0] pc,
    input  ex_ctrl_t         ctrl,
    output logic [`XLEN-1:0] ex_op_a,
    output logic [`XLEN-1:0] ex_op_b,
    output logic [`XLEN-1:0] ex_imm,
    output logic [`XLEN-1:0] ex_pc,
    output ex_ctrl_t         ex_ctrl
);

    // Control fields, a bubble is all zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctrl <= '0;
        end else if (flush) begin
            ex_ctrl <= '0;
        end else if (!stall) begin
            ex_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_op_a <= op_a;
            ex_op_b <= op_b;
            ex_imm  <= imm_ext;
            ex_pc   <= pc;
        end
    end

endmodule

//--- execute_stage.sv
`include "mips_settings.svh"

module execute_stage
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [`XLEN-1:0] ex_op_a,
    input  logic [`XLEN-1:0] ex_op_b,
    input  logic [`XLEN-1:0] ex_imm,
    input  logic [`XLEN-1:0] ex_pc,
    input  ex_ctrl_t         ex_ctrl,
    wb_if.master             bus,
    output logic             stall,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_pc,
    output logic             wb_en,
    output logic [4:0]       wb_reg,
    output logic [`XLEN-1:0] wb_data
);

    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic             mem_op;
    logic             mem_done;   // Gap cycle after ack.

    // ##################################################
    // ALU
    // ##################################################
    assign src_b = ex_ctrl.alu_src_imm ? ex_imm : ex_op_b;

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_ADD: alu_res = ex_op_a + src_b;
            ALU_SUB: alu_res = ex_op_a - src_b;
            ALU_AND: alu_res = ex_op_a & src_b;
            ALU_OR:  alu_res = ex_op_a | src_b;
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(ex_op_a) < $signed(src_b)};
            ALU_LUI: alu_res = {src_b[15:0], 16'b0};
            default: alu_res = '0;
        endcase
    end

    // ##################################################
    // Branch and jump
    // ##################################################
    assign pc_plus4 = ex_pc + `XLEN'd4;
    assign redirect = (ex_ctrl.branch & (ex_op_a == ex_op_b)) | ex_ctrl.jump;

    always_comb begin
        if (ex_ctrl.jump) begin
            redirect_pc = {pc_plus4[`XLEN-1:28], ex_imm[25:0], 2'b00};
        end else begin
            redirect_pc = pc_plus4 + {ex_imm[`XLEN-3:0], 2'b00};
        end
    end

    // ##################################################
    // Data port
    // ##################################################
    assign mem_op    = ex_ctrl.mem_read | ex_ctrl.mem_write;
    assign bus.cyc   = mem_op & ~mem_done;
    assign bus.stb   = mem_op & ~mem_done;
    assign bus.we    = ex_ctrl.mem_write;
    assign bus.adr   = alu_res;
    assign bus.dat_w = ex_op_b;

    assign stall = mem_op & ~bus.ack;   // Held until the word moves.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_done <= 1'b0;
        end else begin
            mem_done <= bus.ack;
        end
    end

    // Writeback on the completing edge.
    assign wb_en   = ex_ctrl.reg_write & (~ex_ctrl.mem_read | bus.ack);
    assign wb_reg  = ex_ctrl.wr_reg;
    assign wb_data = ex_ctrl.mem_read ? bus.dat_r : alu_res;

endmodule

//--- bus_arbiter.sv
`include "mips_settings.svh"

module bus_arbiter (
    input  logic             clk,
    input  logic             rst_n,
    wb_if.slave              fetch_bus,
    wb_if.slave              data_bus,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output logic [`XLEN-1:0] mem_adr,
    output logic [`XLEN-1:0] mem_dat_w,
    input  logic [`XLEN-1:0] mem_dat_r,
    input  logic             mem_ack
);

    logic lock_q;        // Bus was busy last cycle.
    logic lock_data_q;   // Owner last cycle.
    logic hold;
    logic grant_data;

    // Owner keeps the bus while its cyc stays up. Data wins when idle.
    assign hold       = lock_q & (lock_data_q ? data_bus.cyc : fetch_bus.cyc);
    assign grant_data = hold ? lock_data_q : data_bus.cyc;

    always_comb begin
        if (grant_data) begin
            mem_cyc   = data_bus.cyc;
            mem_stb   = data_bus.stb;
            mem_we    = data_bus.we;
            mem_adr   = data_bus.adr;
            mem_dat_w = data_bus.dat_w;
        end else begin
            mem_cyc   = fetch_bus.cyc;
            mem_stb   = fetch_bus.stb;
            mem_we    = fetch_bus.we;
            mem_adr   = fetch_bus.adr;
            mem_dat_w = fetch_bus.dat_w;
        end
    end

    assign fetch_bus.dat_r = mem_dat_r;
    assign data_bus.dat_r  = mem_dat_r;
    assign fetch_bus.ack   = mem_ack & ~grant_data;
    assign data_bus.ack    = mem_ack & grant_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q      <= 1'b0;
            lock_data_q <= 1'b0;
        end else begin
            lock_q      <= mem_cyc;
            lock_data_q <= grant_data;
        end
    end

endmodule

//--- mips_core.sv
`include "mips_settings.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output logic [`XLEN-1:0] mem_adr,
    output logic [`XLEN-1:0] mem_dat_w,
    input  logic [`XLEN-1:0] mem_dat_r,
    input  logic             mem_ack
);

    wb_if fetch_bus ();
    wb_if data_bus ();

    logic [`XLEN-1:0] if_instr, if_pc;
    logic             if_valid;
    logic [`XLEN-1:0] id_op_a, id_op_b, id_imm, id_pc;
    ex_ctrl_t         id_ctrl;
    logic [`XLEN-1:0] ex_op_a, ex_op_b, ex_imm, ex_pc;
    ex_ctrl_t         ex_ctrl;
    logic             stall, redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic             wb_en;
    logic [4:0]       wb_reg;
    logic [`XLEN-1:0] wb_data;

    fetch_unit fetch_unit_inst (
        .clk, .rst_n, .bus(fetch_bus), .stall, .redirect, .redirect_pc,
        .if_instr, .if_pc, .if_valid
    );

    decode_stage decode_stage_inst (
        .clk, .rst_n, .if_instr, .if_pc, .if_valid, .wb_en, .wb_reg, .wb_data,
        .op_a(id_op_a), .op_b(id_op_b), .imm_ext(id_imm), .pc(id_pc), .ctrl(id_ctrl)
    );

    id_ex id_ex_inst (
        .clk, .rst_n, .stall, .flush(redirect),
        .op_a(id_op_a), .op_b(id_op_b), .imm_ext(id_imm), .pc(id_pc), .ctrl(id_ctrl),
        .ex_op_a, .ex_op_b, .ex_imm, .ex_pc, .ex_ctrl
    );

    execute_stage execute_stage_inst (
        .clk, .rst_n, .ex_op_a, .ex_op_b, .ex_imm, .ex_pc, .ex_ctrl, .bus(data_bus),
        .stall, .redirect, .redirect_pc, .wb_en, .wb_reg, .wb_data
    );

    bus_arbiter bus_arbiter_inst (
        .clk, .rst_n, .fetch_bus, .data_bus,
        .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack
    );

endmodule

//--- tb_mips_core.sv
`include "mips_settings.svh"

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int DRAIN_CYCLES   = 40;
    localparam int NUM_STORES     = 11;
    localparam int NUM_TESTS      = 6;
    localparam logic [`XLEN-1:0] DATA_BASE  = 32'h0000_0200;
    localparam logic [`XLEN-1:0] POISON_ADR = 32'h0000_02fc;
    localparam logic [`XLEN-1:0] LOAD_ADR   = 32'h0000_0300;
    localparam logic [`XLEN-1:0] LOAD_WORD  = 32'hcafe_0001;

    localparam int T_RESET = 0;
    localparam int T_IMM   = 1;
    localparam int T_RTYPE = 2;
    localparam int T_LOAD  = 3;
    localparam int T_CTRL  = 4;
    localparam int T_BUS   = 5;

    logic             clk;
    logic             rst_n;
    logic             mem_cyc;
    logic             mem_stb;
    logic             mem_we;
    logic [`XLEN-1:0] mem_adr;
    logic [`XLEN-1:0] mem_dat_w;
    logic [`XLEN-1:0] mem_dat_r;
    logic             mem_ack;

    logic [`XLEN-1:0] mem [MEM_WORDS];
    logic [`XLEN-1:0] exp_adr [NUM_STORES];
    logic [`XLEN-1:0] exp_dat [NUM_STORES];
    int               exp_test [NUM_STORES];
    string            test_name [NUM_TESTS];
    int               test_errs [NUM_TESTS];
    int               checks;
    int               err_total;
    int               tests_passed;
    int               tests_failed;
    int               wr_count;
    int               cycles;
    int               seed = 90707;
    int               waits;
    logic             busy;
    logic             pend;
    logic             pend_we;
    logic             first_fetch;
    logic [`XLEN-1:0] pend_adr;
    logic [`XLEN-1:0] last_fetch;

    mips_core mips_core_inst (
        .clk, .rst_n, .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w,
        .mem_dat_r, .mem_ack
    );

    always #20 clk = ~clk;

    // ##################################################
    // Instruction encoding and program image
    // ##################################################
    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [25:0] target);
        return {6'h02, target};
    endfunction

    // Taken beq lands on word 22, j on word 26, the closing loop on word 27.
    function automatic logic is_redirect_target(input logic [`XLEN-1:0] adr);
        return adr == `RESET_PC + 32'd88 || adr == `RESET_PC + 32'd104
            || adr == `RESET_PC + 32'd108;
    endfunction

    task automatic place(input int idx, input logic [31:0] w);
        mem[(`RESET_PC >> 2) + idx] = w;
    endtask

    task automatic expect_store(input int i, input logic [`XLEN-1:0] adr,
                                input logic [`XLEN-1:0] dat, input int t);
        exp_adr[i]  = adr;
        exp_dat[i]  = dat;
        exp_test[i] = t;
    endtask

    task automatic load_program();
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r10;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = 32'h5a00_0000 | (k << 2);  // Unused opcode, so a no-op.
        end
        mem[LOAD_ADR[9:2]] = LOAD_WORD;
        place(0, itype_word(6'h0f, 5'd0, 5'd1, 16'h1234));   // lui r1.
        place(1, itype_word(6'h0d, 5'd1, 5'd1, 16'h8765));   // ori r1, r1.
        place(2, itype_word(6'h09, 5'd0, 5'd2, 16'hfffb));   // addiu r2, r0, -5.
        place(3, itype_word(6'h2b, 5'd0, 5'd1, 16'h0200));
        place(4, itype_word(6'h2b, 5'd0, 5'd2, 16'h0204));
        place(5, rtype_word(5'd1, 5'd2, 5'd3, 6'h21));       // addu r3.
        place(6, rtype_word(5'd1, 5'd3, 5'd4, 6'h23));       // subu r4, r1, r3.
        place(7, rtype_word(5'd1, 5'd2, 5'd5, 6'h24));       // and r5.
        place(8, rtype_word(5'd5, 5'd4, 5'd6, 6'h25));       // or r6, r5, r4.
        place(9, rtype_word(5'd2, 5'd1, 5'd7, 6'h2a));       // slt r7, r2, r1.
        place(10, rtype_word(5'd1, 5'd2, 5'd8, 6'h2a));      // slt r8, r1, r2.
        for (int k = 0; k < 6; k++) begin
            place(11 + k, itype_word(6'h2b, 5'd0, 5'(3 + k), 16'(16'h0208 + 4 * k)));
        end
        place(17, itype_word(6'h23, 5'd0, 5'd9, LOAD_ADR[15:0]));  // lw r9.
        place(18, itype_word(6'h09, 5'd9, 5'd10, 16'h0010));       // Uses r9 at once.
        place(19, itype_word(6'h2b, 5'd0, 5'd10, 16'h0220));
        place(20, itype_word(6'h04, 5'd1, 5'd1, 16'h0001));   // Taken beq.
        place(21, itype_word(6'h2b, 5'd0, 5'd1, POISON_ADR[15:0]));
        place(22, itype_word(6'h04, 5'd1, 5'd2, 16'h0001));   // Not taken.
        place(23, itype_word(6'h2b, 5'd0, 5'd2, 16'h0224));
        place(24, jump_word(26'((`RESET_PC >> 2) + 26)));
        place(25, itype_word(6'h2b, 5'd0, 5'd1, POISON_ADR[15:0]));
        place(26, itype_word(6'h2b, 5'd0, 5'd6, 16'h0228));
        place(27, jump_word(26'((`RESET_PC >> 2) + 27)));   // Spin here.
        place(28, itype_word(6'h2b, 5'd0, 5'd1, POISON_ADR[15:0]));

        r1  = {16'h1234, 16'h0000} | {16'h0000, 16'h8765};
        r2  = {{16{1'b1}}, 16'hfffb};
        r3  = r1 + r2;
        r4  = r1 - r3;
        r5  = r1 & r2;
        r6  = r5 | r4;
        r7  = ($signed(r2) < $signed(r1)) ? 32'd1 : 32'd0;
        r8  = ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
        r10 = LOAD_WORD + 32'd16;
        expect_store(0, 32'h200, r1, T_IMM);
        expect_store(1, 32'h204, r2, T_IMM);
        expect_store(2, 32'h208, r3, T_RTYPE);
        expect_store(3, 32'h20c, r4, T_RTYPE);
        expect_store(4, 32'h210, r5, T_RTYPE);
        expect_store(5, 32'h214, r6, T_RTYPE);
        expect_store(6, 32'h218, r7, T_RTYPE);
        expect_store(7, 32'h21c, r8, T_RTYPE);
        expect_store(8, 32'h220, r10, T_LOAD);
        expect_store(9, 32'h224, r2, T_CTRL);
        expect_store(10, 32'h228, r6, T_CTRL);
    endtask

    // ##################################################
    // Checks and reporting
    // ##################################################
    task automatic note_error(input int t);
        test_errs[t]++;
        err_total++;
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            tests_passed++;
            $display("test %s passed", test_name[t]);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name[t], test_errs[t]);
        end
    endtask

    task automatic check_store();
        int t;
        checks++;
        assert (mem_adr != POISON_ADR) else begin
            $display("[%s] a skipped store reached the poison address", test_name[T_CTRL]);
            note_error(T_CTRL);
        end
        if (mem_adr == POISON_ADR) return;
        checks++;
        assert (wr_count < NUM_STORES) else begin
            $display("[%s] extra store to %h after the last one", test_name[T_CTRL], mem_adr);
            note_error(T_CTRL);
        end
        if (wr_count >= NUM_STORES) return;
        t = exp_test[wr_count];
        checks += 2;
        assert (mem_adr == exp_adr[wr_count]) else begin
            $display("** Error [%s] store %0d address expected %h, actual %h",
                     test_name[t], wr_count, exp_adr[wr_count], mem_adr);
            note_error(t);
        end
        assert (mem_dat_w == exp_dat[wr_count]) else begin
            $display("** Error [%s] store %0d data expected %h, actual %h",
                     test_name[t], wr_count, exp_dat[wr_count], mem_dat_w);
            note_error(t);
        end
        wr_count++;
        if (wr_count == NUM_STORES || exp_test[wr_count] != t) report_test(t);
    endtask

    task automatic check_fetch();
        checks++;
        if (first_fetch) begin
            first_fetch = 1'b0;
            assert (mem_adr == `RESET_PC) else begin
                $display("** Error [%s] first fetch expected %h, actual %h",
                         test_name[T_RESET], `RESET_PC, mem_adr);
                note_error(T_RESET);
            end
            report_test(T_RESET);
        end else begin
            // A dropped word is fetched again from the same address.
            assert (mem_adr == last_fetch + 32'd4 || mem_adr == last_fetch
                    || is_redirect_target(mem_adr)) else begin
                $display("** Error [%s] fetch address expected %h, actual %h",
                         test_name[T_BUS], last_fetch + 32'd4, mem_adr);
                note_error(T_BUS);
            end
        end
        last_fetch = mem_adr;
    endtask

    task automatic complete_access();
        if (mem_adr[`XLEN-1:10] != '0) begin
            $display("[%s] access outside the memory at %h", test_name[T_BUS], mem_adr);
            note_error(T_BUS);
            mem_dat_r <= '0;
        end else if (mem_we) begin
            check_store();
            mem[mem_adr[9:2]] = mem_dat_w;
        end else begin
            mem_dat_r <= mem[mem_adr[9:2]];
            if (mem_adr < DATA_BASE) check_fetch();
        end
    endtask

    // ##################################################
    // Memory model
    // ##################################################
    always @(negedge clk) begin
        if (!rst_n) begin
            checks++;
            assert (!mem_cyc && !mem_stb) else begin
                $display("[%s] bus active while in reset", test_name[T_RESET]);
                note_error(T_RESET);
            end
            mem_ack <= 1'b0;
            busy = 1'b0;
            pend = 1'b0;
        end else begin
            if (pend) begin
                checks++;
                assert (mem_cyc && mem_stb && mem_adr == pend_adr && mem_we == pend_we)
                else begin
                    $display("[%s] request at %h dropped or changed before ack",
                             test_name[T_BUS], pend_adr);
                    note_error(T_BUS);
                end
            end
            if (mem_ack) begin
                mem_ack <= 1'b0;       // Ack lasts one cycle.
                busy = 1'b0;
                pend = mem_stb;
            end else if (mem_stb) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = $random(seed) & 3;
                end
                if (waits == 0) begin
                    complete_access();
                    mem_ack <= 1'b1;
                    busy = 1'b0;
                    pend = 1'b0;
                end else begin
                    waits--;
                    pend = 1'b1;
                end
            end else begin
                pend = 1'b0;
            end
            pend_adr = mem_adr;
            pend_we  = mem_we;
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        mem_ack      = 1'b0;
        mem_dat_r    = '0;
        test_name    = '{"reset_state", "immediates", "r_type", "load_use",
                         "control_flow", "bus_sharing"};
        test_errs    = '{default: 0};
        checks       = 0;
        err_total    = 0;
        tests_passed = 0;
        tests_failed = 0;
        wr_count     = 0;
        busy         = 1'b0;
        pend         = 1'b0;
        first_fetch  = 1'b1;
        last_fetch   = '0;
        load_program();

        repeat (2) @(negedge clk);
        rst_n <= 1'b1;

        for (cycles = 0; cycles < TIMEOUT_CYCLES && wr_count < NUM_STORES; cycles++) begin
            @(negedge clk);
        end
        checks++;
        assert (wr_count == NUM_STORES) else begin
            $display("[%s] timeout, %0d of %0d stores arrived",
                     test_name[exp_test[wr_count]], wr_count, NUM_STORES);
            note_error(exp_test[wr_count]);
            if (first_fetch) report_test(T_RESET);
            for (int k = wr_count; k < NUM_STORES; k++) begin
                if (k == NUM_STORES - 1 || exp_test[k + 1] != exp_test[k]) begin
                    report_test(exp_test[k]);
                end
            end
        end

        // Late stores from flushed instructions would show up here.
        for (cycles = 0; cycles < DRAIN_CYCLES; cycles++) begin
            @(negedge clk);
        end
        report_test(T_BUS);
        $display("summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, err_total);
        if (err_total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
mips_pkg.sv
wb_if.sv
fetch_unit.sv
decode_stage.sv
id_ex.sv
execute_stage.sv
bus_arbiter.sv
mips_core.sv
tb_mips_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mips_core -f all.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -q "^NO ERRORS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
